/* hdl/eeprom_pkg.sv */
package eeprom_pkg;

    localparam int QUARTER_CYCLES = 2;  // CLK cycles per quarter of an SCL period
    localparam int QUARTER_W = (QUARTER_CYCLES > 1) ? $clog2(QUARTER_CYCLES) : 1;

    localparam logic [3:0] DEVICE_TYPE = 4'b1010;

    typedef logic [10:0] ee_addr_t;
    typedef logic [7:0] ee_byte_t;
    typedef logic [QUARTER_W-1:0] quarter_cnt_t;
    typedef logic [1:0] quarter_idx_t;
    typedef logic [3:0] bit_cnt_t;  // 8 data bits, then the ack slot at 0

    // one-cycle strobes inside one SCL bit period
    typedef struct packed {
        logic low_mid;   // sda may change
        logic rise;
        logic high_mid;  // sample point, start/stop edge
        logic fall;
    } bit_phase_t;

    typedef enum logic {
        COND_START,
        COND_STOP
    } cond_kind_t;

    typedef struct packed {
        logic     go;
        logic     read;
        ee_byte_t tx_byte;
        logic     master_ack;  // 1 = nack after a received byte
    } shift_cmd_t;

    typedef struct packed {
        logic     done;
        ee_byte_t rx_byte;
        logic     slave_nack;
    } shift_rsp_t;

    typedef enum logic [3:0] {
        IDLE, START, CTRL_W, ADDR, DATA_W,
        RESTART, CTRL_R, DATA_R, STOP, FINISH
    } main_state_t;

endpackage

/* hdl/scl_phase_gen.sv */
module scl_phase_gen (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   run,
    output logic                   scl,
    output eeprom_pkg::bit_phase_t phase
);
    import eeprom_pkg::*;

    quarter_cnt_t cnt;
    quarter_idx_t quarter;
    logic         tick;

    // end of the current quarter
    assign tick = run && (cnt == quarter_cnt_t'(QUARTER_CYCLES - 1));

    always_ff @(posedge CLK) begin
        if (RESET || !run) begin
            cnt     <= '0;
            quarter <= '0;
        end else if (tick) begin
            cnt     <= '0;
            quarter <= quarter + 1'b1;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // quarters 0,1 low, 2,3 high; bus idles high
    assign scl = !run || quarter[1];

    always_comb begin
        phase.low_mid  = tick && (quarter == 2'd0);
        phase.rise     = tick && (quarter == 2'd1);
        phase.high_mid = tick && (quarter == 2'd2);
        phase.fall     = tick && (quarter == 2'd3);
    end

endmodule

/* hdl/bus_condition.sv */
module bus_condition (
    input  logic                   CLK,
    input  logic                   RESET,
    input  eeprom_pkg::bit_phase_t phase,
    input  logic                   cond_go,
    input  eeprom_pkg::cond_kind_t cond_kind,
    output logic                   sda_low,
    output logic                   cond_done
);
    import eeprom_pkg::*;

    typedef enum logic [1:0] {
        C_IDLE,
        C_BEGIN,
        C_BIT,
        C_END
    } cond_state_t;

    cond_state_t state;
    cond_kind_t  kind;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state   <= C_IDLE;
            sda_low <= 1'b0;
        end else begin
            case (state)
                C_IDLE: begin
                    if (cond_go) begin
                        kind  <= cond_kind;
                        state <= C_BEGIN;
                    end else if (phase.low_mid) begin
                        sda_low <= 1'b0;  // start level handed over to the shifter
                    end
                end
                C_BEGIN: begin
                    if (phase.low_mid) begin
                        sda_low <= (kind == COND_STOP);
                        state   <= C_BIT;
                    end
                end
                C_BIT: begin
                    if (phase.high_mid) begin
                        sda_low <= (kind == COND_START);  // edge while scl high
                        state   <= (kind == COND_STOP) ? C_IDLE : C_END;
                    end
                end
                default: begin
                    if (phase.fall) begin
                        state <= C_IDLE;
                    end
                end
            endcase
        end
    end

    assign cond_done = (state == C_END && phase.fall) ||
                       (state == C_BIT && kind == COND_STOP && phase.high_mid);

    a_go_when_idle: assert property (@(posedge CLK) disable iff (RESET)
        cond_go |-> state == C_IDLE)
        else $error("bus_condition: cond_go while a condition is running");

endmodule

/* hdl/byte_shifter.sv */
module byte_shifter (
    input  logic                   CLK,
    input  logic                   RESET,
    input  eeprom_pkg::bit_phase_t phase,
    input  logic                   sda_in,
    input  eeprom_pkg::shift_cmd_t cmd,
    output logic                   sda_low,
    output eeprom_pkg::shift_rsp_t rsp
);
    import eeprom_pkg::*;

    ee_byte_t shreg;
    bit_cnt_t cnt;
    logic     busy;
    logic     read;
    logic     master_ack;
    logic     ack_q;
    logic     last_slot;

    assign last_slot = (cnt == '0);  // ninth bit, the acknowledge

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy    <= 1'b0;
            cnt     <= '0;
            sda_low <= 1'b0;
        end else if (!busy) begin
            if (cmd.go) begin
                busy       <= 1'b1;
                cnt        <= bit_cnt_t'(8);
                read       <= cmd.read;
                shreg      <= cmd.tx_byte;
                master_ack <= cmd.master_ack;
            end else if (phase.low_mid) begin
                sda_low <= 1'b0;  // drop the last ack level
            end
        end else begin
            if (phase.low_mid) begin
                if (!last_slot) begin
                    sda_low <= !read && !shreg[7];  // msb first
                end else begin
                    sda_low <= read && !master_ack;
                end
            end
            if (phase.high_mid) begin
                if (!last_slot) begin
                    shreg <= {shreg[6:0], sda_in};
                end else begin
                    ack_q <= sda_in;
                end
            end
            if (phase.fall) begin
                if (last_slot) begin
                    busy <= 1'b0;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    // on a send, shreg has shifted out completely and rx_byte holds the read-back
    assign rsp = shift_rsp_t'{
        done:       busy && last_slot && phase.fall,
        rx_byte:    shreg,
        slave_nack: ack_q
    };

    a_go_when_idle: assert property (@(posedge CLK) disable iff (RESET)
        cmd.go |-> !busy)
        else $error("byte_shifter: go while a byte is in flight");

endmodule

/* hdl/eeprom_ctrl.sv */
module eeprom_ctrl (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   wr,
    input  logic                   rd,
    input  eeprom_pkg::ee_addr_t   addr,
    input  eeprom_pkg::ee_byte_t   wr_data,
    output logic                   run,
    output logic                   cond_go,
    output eeprom_pkg::cond_kind_t cond_kind,
    input  logic                   cond_done,
    input  logic                   cond_sda_low,
    output eeprom_pkg::shift_cmd_t shift_cmd,
    input  eeprom_pkg::shift_rsp_t shift_rsp,
    input  logic                   shift_sda_low,
    output logic                   sda_oe,
    output logic                   busy,
    output logic                   done,
    output logic                   nack,
    output eeprom_pkg::ee_byte_t   rd_data
);
    import eeprom_pkg::*;

    main_state_t state;
    logic        is_read;
    ee_addr_t    addr_q;
    ee_byte_t    data_q;
    logic        accept;

    assign accept = (state == IDLE) && (wr || rd);
    assign busy   = (state != IDLE);
    assign sda_oe = run && (cond_sda_low || shift_sda_low);

    // device type, block select from addr[10:8], r/w bit
    function automatic ee_byte_t ctrl_byte(input logic rnw);
        return {DEVICE_TYPE, addr_q[10:8], rnw};
    endfunction

    function automatic shift_cmd_t send(input ee_byte_t b);
        return shift_cmd_t'{go: 1'b1, read: 1'b0, tx_byte: b, master_ack: 1'b1};
    endfunction

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state        <= IDLE;
            run          <= 1'b0;
            cond_go      <= 1'b0;
            cond_kind    <= COND_STOP;
            shift_cmd.go <= 1'b0;
            done         <= 1'b0;
            nack         <= 1'b0;
        end else begin
            cond_go      <= 1'b0;
            shift_cmd.go <= 1'b0;
            done         <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        is_read   <= !wr;  // write wins if both strobes arrive
                        addr_q    <= addr;
                        data_q    <= wr_data;
                        nack      <= 1'b0;
                        run       <= 1'b1;
                        cond_go   <= 1'b1;
                        cond_kind <= COND_START;
                        state     <= START;
                    end
                end
                START: if (cond_done) begin
                    shift_cmd <= send(ctrl_byte(1'b0));
                    state     <= CTRL_W;
                end
                CTRL_W: if (shift_rsp.done) begin
                    shift_cmd <= send(addr_q[7:0]);
                    state     <= ADDR;
                end
                ADDR: if (shift_rsp.done) begin
                    if (is_read) begin
                        cond_go   <= 1'b1;
                        cond_kind <= COND_START;
                        state     <= RESTART;
                    end else begin
                        shift_cmd <= send(data_q);
                        state     <= DATA_W;
                    end
                end
                RESTART: if (cond_done) begin
                    shift_cmd <= send(ctrl_byte(1'b1));
                    state     <= CTRL_R;
                end
                CTRL_R: if (shift_rsp.done) begin
                    shift_cmd <= shift_cmd_t'{go: 1'b1, read: 1'b1, tx_byte: 8'hff,
                                              master_ack: 1'b1};
                    state     <= DATA_R;
                end
                DATA_W, DATA_R: if (shift_rsp.done) begin
                    if (state == DATA_R) begin
                        rd_data <= shift_rsp.rx_byte;
                    end
                    cond_go   <= 1'b1;
                    cond_kind <= COND_STOP;
                    state     <= STOP;
                end
                STOP: if (cond_done) begin
                    run   <= 1'b0;
                    done  <= 1'b1;
                    state <= FINISH;
                end
                default: state <= IDLE;  // FINISH holds the done pulse
            endcase

            // slave refused the byte so abort with a stop
            if (shift_rsp.done && shift_rsp.slave_nack &&
                (state inside {CTRL_W, ADDR, CTRL_R, DATA_W})) begin
                nack         <= 1'b1;
                shift_cmd.go <= 1'b0;
                cond_go      <= 1'b1;
                cond_kind    <= COND_STOP;
                state        <= STOP;
            end
        end
    end

    a_cond_done_expected: assert property (@(posedge CLK) disable iff (RESET)
        cond_done |-> state inside {START, RESTART, STOP})
        else $error("eeprom_ctrl: cond_done while no condition was issued");

endmodule

/* hdl/eeprom_wr.sv */
module eeprom_wr (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wr,
    input  logic                 rd,
    input  eeprom_pkg::ee_addr_t addr,
    input  eeprom_pkg::ee_byte_t wr_data,
    input  logic                 sda_in,
    output logic                 scl,
    output logic                 sda_oe,
    output logic                 busy,
    output logic                 done,
    output logic                 nack,
    output eeprom_pkg::ee_byte_t rd_data
);
    import eeprom_pkg::*;

    logic       run;
    bit_phase_t phase;
    logic       cond_go;
    cond_kind_t cond_kind;
    logic       cond_done;
    logic       cond_sda_low;
    shift_cmd_t shift_cmd;
    shift_rsp_t shift_rsp;
    logic       shift_sda_low;

    eeprom_ctrl i_ctrl (
        .CLK           (CLK),
        .RESET         (RESET),
        .wr            (wr),
        .rd            (rd),
        .addr          (addr),
        .wr_data       (wr_data),
        .run           (run),
        .cond_go       (cond_go),
        .cond_kind     (cond_kind),
        .cond_done     (cond_done),
        .cond_sda_low  (cond_sda_low),
        .shift_cmd     (shift_cmd),
        .shift_rsp     (shift_rsp),
        .shift_sda_low (shift_sda_low),
        .sda_oe        (sda_oe),
        .busy          (busy),
        .done          (done),
        .nack          (nack),
        .rd_data       (rd_data)
    );

    scl_phase_gen i_scl_phase_gen (
        .CLK   (CLK),
        .RESET (RESET),
        .run   (run),
        .scl   (scl),
        .phase (phase)
    );

    bus_condition i_bus_condition (
        .CLK       (CLK),
        .RESET     (RESET),
        .phase     (phase),
        .cond_go   (cond_go),
        .cond_kind (cond_kind),
        .sda_low   (cond_sda_low),
        .cond_done (cond_done)
    );

    byte_shifter i_byte_shifter (
        .CLK     (CLK),
        .RESET   (RESET),
        .phase   (phase),
        .sda_in  (sda_in),
        .cmd     (shift_cmd),
        .sda_low (shift_sda_low),
        .rsp     (shift_rsp)
    );

endmodule

/* verification/eeprom_slave_model.sv */
module eeprom_slave_model (
    input  logic scl,
    input  logic sda,
    input  logic mute,
    output logic sda_low
);
    timeunit 1ns;
    timeprecision 1ps;
    import eeprom_pkg::*;

    typedef enum {
        S_IDLE,
        S_CTRL,
        S_ADDR,
        S_WDATA,
        S_RDATA
    } slave_state_t;

    ee_byte_t     mem [0:2047];
    slave_state_t state;
    ee_byte_t     shreg;
    int           bit_cnt;
    logic         in_ack;  // slave owns the ninth slot
    logic         acked;
    logic         rnw;
    logic [2:0]   block;
    ee_addr_t     ptr;
    logic         scl_q;
    logic         sda_q;

    initial begin
        for (int a = 0; a < 2048; a++) begin
            mem[a] = ~(a[7:0] ^ {a[10:8], 5'b0});  // erased look mixing in every address bit
        end
        sda_low = 1'b0;
        state   = S_IDLE;
        bit_cnt = 0;
        in_ack  = 1'b0;
        acked   = 1'b0;
        rnw     = 1'b0;
        block   = '0;
        ptr     = '0;
        scl_q   = 1'b1;
        sda_q   = 1'b1;
    end

    task sample_bit();
        if (state inside {S_CTRL, S_ADDR, S_WDATA} && !in_ack && bit_cnt < 8) begin
            shreg   = {shreg[6:0], sda};
            bit_cnt = bit_cnt + 1;
        end
    endtask

    task drive_bit();
        if (in_ack) begin
            sda_low = 1'b0;
            in_ack  = 1'b0;
            bit_cnt = 0;
            if (!acked) begin
                state = S_IDLE;
            end else if (state == S_CTRL && rnw) begin
                state   = S_RDATA;
                shreg   = mem[ptr];
                sda_low = !shreg[7];  // msb right after the ack
                bit_cnt = 1;
            end else if (state == S_CTRL) begin
                state = S_ADDR;
            end else if (state == S_ADDR) begin
                state = S_WDATA;
            end else begin
                state = S_IDLE;  // single byte writes only
            end
        end else if (state inside {S_CTRL, S_ADDR, S_WDATA} && bit_cnt == 8) begin
            case (state)
                S_CTRL: begin
                    acked = !mute && (shreg[7:4] == DEVICE_TYPE);
                    rnw   = shreg[0];
                    if (acked && !rnw) begin
                        block = shreg[3:1];
                    end
                end
                S_ADDR: begin
                    acked = !mute;
                    ptr   = {block, shreg};
                end
                default: begin
                    acked = !mute;
                    if (acked) begin
                        mem[ptr] = shreg;
                    end
                end
            endcase
            sda_low = acked;
            in_ack  = 1'b1;
        end else if (state == S_RDATA) begin
            if (bit_cnt < 8) begin
                sda_low = !shreg[7 - bit_cnt];
                bit_cnt = bit_cnt + 1;
            end else begin
                sda_low = 1'b0;  // master acks or nacks here
                state   = S_IDLE;
            end
        end
    endtask

    always @(scl or sda) begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
            state   = S_CTRL;  // start or repeated start
            bit_cnt = 0;
            in_ack  = 1'b0;
            sda_low = 1'b0;
        end else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
            state   = S_IDLE;  // stop
            in_ack  = 1'b0;
            sda_low = 1'b0;
        end else if (scl === 1'b1 && scl_q === 1'b0) begin
            sample_bit();
        end else if (scl === 1'b0 && scl_q === 1'b1) begin
            drive_bit();
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* verification/tb_eeprom_wr.sv */
module tb_eeprom_wr;
    timeunit 1ns;
    timeprecision 1ps;
    import eeprom_pkg::*;

    localparam int DONE_TIMEOUT = 2000;
    localparam int QUIET_CYCLES = 100;
    localparam int N_RANDOM     = 40;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    ee_addr_t    addr;
    ee_byte_t    wr_data;
    logic        sda_in;
    logic        scl;
    logic        sda_oe;
    logic        busy;
    logic        done;
    logic        nack;
    ee_byte_t    rd_data;
    logic        mute;
    logic        slave_sda_low;

    ee_byte_t    shadow [0:2047];
    logic [31:0] lcg_state;
    int          n_tests;
    int          n_checks;
    int          n_errors;

    assign sda_in = !sda_oe && !slave_sda_low;  // open drain line

    eeprom_wr i_eeprom_wr (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .sda_in  (sda_in),
        .scl     (scl),
        .sda_oe  (sda_oe),
        .busy    (busy),
        .done    (done),
        .nack    (nack),
        .rd_data (rd_data)
    );

    eeprom_slave_model i_slave (
        .scl     (scl),
        .sda     (sda_in),
        .mute    (mute),
        .sda_low (slave_sda_low)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // same contents the slave powers up with
    function automatic ee_byte_t erased_value(input ee_addr_t a);
        return ~(a[7:0] ^ {a[10:8], 5'b0});
    endfunction

    task automatic check_byte(input string name, input ee_byte_t got, input ee_byte_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int c0, input int e0);
        n_tests++;
        $display("test %-16s checks %0d  errors %0d", name, n_checks - c0, n_errors - e0);
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy !== 1'b0 && cycles < DONE_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (busy !== 1'b0) begin
            n_errors++;
            $display("timeout: busy still high after %0d cycles", DONE_TIMEOUT);
        end
    endtask

    task automatic wait_done(output ee_byte_t got, output logic got_nack);
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        got      = rd_data;
        got_nack = nack;
        if (done !== 1'b1) begin
            n_errors++;
            $display("timeout: no done pulse within %0d cycles", DONE_TIMEOUT);
        end
    endtask

    task automatic run_op(input logic is_read, input ee_addr_t a, input ee_byte_t d,
                          output ee_byte_t got, output logic got_nack);
        wait_idle();
        wr      = !is_read;
        rd      = is_read;
        addr    = a;
        wr_data = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        wait_done(got, got_nack);
    endtask

    task automatic write_byte(input ee_addr_t a, input ee_byte_t d);
        ee_byte_t got;
        logic     gn;
        run_op(1'b0, a, d, got, gn);
        check_flag("nack", gn, 1'b0);
        shadow[a] = d;
    endtask

    task automatic read_check(input ee_addr_t a);
        ee_byte_t got;
        logic     gn;
        run_op(1'b1, a, '0, got, gn);
        check_byte($sformatf("rd_data @%h", a), got, shadow[a]);
        check_flag("nack", gn, 1'b0);
    endtask

    task automatic idle_after_reset();
        int c0;
        int e0;
        c0 = n_checks;
        e0 = n_errors;
        @(negedge CLK);
        check_flag("scl", scl, 1'b1);
        check_flag("sda_oe", sda_oe, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("nack", nack, 1'b0);
        report_test("idle_after_reset", c0, e0);
    endtask

    task automatic write_then_read();
        int          c0;
        int          e0;
        logic [31:0] r;
        c0 = n_checks;
        e0 = n_errors;
        r  = next_rand();
        write_byte(r[26:16], r[7:0]);
        read_check(r[26:16]);
        report_test("write_read_back", c0, e0);
    endtask

    task automatic random_mix();
        int          c0;
        int          e0;
        logic [31:0] r;
        ee_addr_t    a;
        ee_addr_t    last_a;
        c0     = n_checks;
        e0     = n_errors;
        last_a = '0;
        for (int i = 0; i < N_RANDOM; i++) begin
            r = next_rand();
            a = r[26:16];
            if (r[31]) begin
                if (r[30]) begin
                    a = last_a;  // often hit a written byte
                end
                read_check(a);
            end else begin
                write_byte(a, r[7:0]);
                last_a = a;
            end
        end
        report_test("random_mix", c0, e0);
    endtask

    task automatic ignore_busy_strobe();
        int          c0;
        int          e0;
        int          cycles;
        int          extra;
        logic [31:0] r;
        ee_addr_t    a1;
        ee_addr_t    a2;
        ee_byte_t    got;
        logic        gn;
        c0 = n_checks;
        e0 = n_errors;
        r  = next_rand();
        a1 = r[26:16];
        a2 = a1 ^ 11'h4c3;  // other block, other offset
        wait_idle();
        wr      = 1'b1;
        addr    = a1;
        wr_data = r[7:0];
        @(negedge CLK);
        wr     = 1'b0;
        cycles = 0;
        while (busy !== 1'b1 && cycles < DONE_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (busy !== 1'b1) begin
            n_errors++;
            $display("timeout: busy never rose after the write strobe");
        end
        wr      = 1'b1;
        addr    = a2;
        wr_data = ~r[7:0];
        @(negedge CLK);
        wr = 1'b0;
        wait_done(got, gn);
        check_flag("nack", gn, 1'b0);
        shadow[a1] = r[7:0];
        extra = 0;
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge CLK);
            if (done === 1'b1 || busy === 1'b1) begin
                extra++;
            end
        end
        n_checks++;
        if (extra != 0) begin
            n_errors++;
            $display("a write strobe while busy started a second operation");
        end
        read_check(a2);
        read_check(a1);
        report_test("busy_strobe", c0, e0);
    endtask

    task automatic missing_slave();
        int          c0;
        int          e0;
        logic [31:0] r;
        ee_byte_t    got;
        logic        gn;
        c0   = n_checks;
        e0   = n_errors;
        r    = next_rand();
        mute = 1'b1;
        run_op(1'b0, r[26:16], r[7:0], got, gn);
        check_flag("nack", gn, 1'b1);
        wait_idle();
        check_flag("scl", scl, 1'b1);
        check_flag("sda_oe", sda_oe, 1'b0);
        check_flag("busy", busy, 1'b0);
        mute = 1'b0;
        read_check(r[26:16]);  // aborted write leaves the byte alone
        report_test("missing_slave", c0, e0);
    endtask

    initial begin
        RESET     = 1'b1;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        wr_data   = '0;
        mute      = 1'b0;
        lcg_state = 32'h00e5b5af;
        n_tests   = 0;
        n_checks  = 0;
        n_errors  = 0;
        for (int a = 0; a < 2048; a++) begin
            shadow[a] = erased_value(ee_addr_t'(a));
        end
        repeat (16) @(negedge CLK);
        RESET = 1'b0;

        idle_after_reset();
        write_then_read();
        random_mix();
        ignore_busy_strobe();
        missing_slave();

        $display("tests %0d  checks %0d  errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
hdl/eeprom_pkg.sv
hdl/scl_phase_gen.sv
hdl/bus_condition.sv
hdl/byte_shifter.sv
hdl/eeprom_ctrl.sv
hdl/eeprom_wr.sv
verification/eeprom_slave_model.sv
verification/tb_eeprom_wr.sv

/* Bender.yml */
package:
  name: eeprom_wr

sources:
  - hdl/eeprom_pkg.sv
  - hdl/scl_phase_gen.sv
  - hdl/bus_condition.sv
  - hdl/byte_shifter.sv
  - hdl/eeprom_ctrl.sv
  - hdl/eeprom_wr.sv
  - target: test
    files:
      - verification/eeprom_slave_model.sv
      - verification/tb_eeprom_wr.sv
